// ==== common/bram_ctrl_consts.svh ====
`ifndef BRAM_CTRL_CONSTS_SVH
`define BRAM_CTRL_CONSTS_SVH

// ========================================
// Bus widths
// ========================================

// Byte address, AXI and BRAM side alike
`define BC_ADDR_W 32
`define BC_DATA_W 32   // One memory word
`define BC_STRB_W 4    // One strobe bit per byte lane

// ========================================
// AXI response codes
// ========================================
`define BC_RESP_OKAY 2'b00  // No error path, always OKAY

`endif

// ==== common/bram_ctrl_pkg.sv ====
`include "bram_ctrl_consts.svh"

package bram_ctrl_pkg;

  // One memory word, seen whole or as byte lanes
  typedef union packed {
    logic [`BC_DATA_W-1:0]       word;   // BRAM side view
    logic [`BC_STRB_W-1:0][7:0]  bytes;  // Merge view, lane 0 is the low byte
  } mem_word_u;

  // Master that owns the BRAM access in progress
  typedef enum logic [1:0] {
    OWNER_NONE = 2'd0,  // Sequencer free
    OWNER_AXI  = 2'd1,
    OWNER_DBG  = 2'd2
  } owner_e;

endpackage

// ==== common/mem_req_if.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

// Single word access, one request in flight
interface mem_req_if;
  import bram_ctrl_pkg::*;

  logic                  valid;  // Held until done
  logic                  write;  // 1 = merge write, 0 = read
  logic [`BC_ADDR_W-1:0] addr;
  mem_word_u             wdata;
  logic [`BC_STRB_W-1:0] wstrb;
  logic                  done;   // One cycle pulse
  mem_word_u             rdata;  // Valid with done only

  // Side that issues the access
  modport requester (
    output valid, write, addr, wdata, wstrb,
    input  done, rdata
  );

  // Side that carries it out
  modport server (
    input  valid, write, addr, wdata, wstrb,
    output done, rdata
  );

endinterface

// ==== rtl/axi_lite_front.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

module axi_lite_front (
  input  logic                  clk,
  input  logic                  rst_n,
  // Write address and data channels
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`BC_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [`BC_DATA_W-1:0] wdata,
  input  logic [`BC_STRB_W-1:0] wstrb,
  // Write response channel
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  // Read channels
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [`BC_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [`BC_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  mem_req_if.requester          req
);

  typedef enum logic [1:0] {
    S_IDLE,   // Ready to accept
    S_BUSY,   // Request in flight
    S_WRESP,  // Waiting on bready
    S_RRESP   // Waiting on rready
  } state_e;

  state_e                state;
  logic                  wr_accept;
  logic                  rd_accept;
  logic                  write_q;
  logic [`BC_ADDR_W-1:0] addr_q;
  logic [`BC_DATA_W-1:0] wdata_q;
  logic [`BC_STRB_W-1:0] wstrb_q;
  logic [`BC_DATA_W-1:0] rdata_q;

  // ========================================
  // Accept, write wins over read
  // ========================================
  assign wr_accept = (state == S_IDLE) && awvalid && wvalid;
  assign rd_accept = (state == S_IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = wr_accept;  // AW and W pulse together
  assign wready  = wr_accept;
  assign arready = rd_accept;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (wr_accept || rd_accept) state <= S_BUSY;
        S_BUSY:  if (req.done) state <= write_q ? S_WRESP : S_RRESP;
        S_WRESP: if (bready) state <= S_IDLE;
        S_RRESP: if (rready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Latches for the accepted request and the read word
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      write_q <= 1'b1;
      addr_q  <= awaddr;
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end else if (rd_accept) begin
      write_q <= 1'b0;
      addr_q  <= araddr;  // Strobes unused on reads
    end
    if (state == S_BUSY && req.done) rdata_q <= req.rdata.word;
  end

  // ========================================
  // Request and responses
  // ========================================
  assign req.valid      = (state == S_BUSY);  // One cycle after accept
  assign req.write      = write_q;
  assign req.addr       = addr_q;
  assign req.wdata.word = wdata_q;
  assign req.wstrb      = wstrb_q;

  assign bvalid = (state == S_WRESP);  // Held until bready
  assign rvalid = (state == S_RRESP);
  assign rdata  = rdata_q;
  assign bresp  = `BC_RESP_OKAY;
  assign rresp  = `BC_RESP_OKAY;

  // Responses stay up until the master takes them
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== rtl/access_arbiter.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

module access_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  mem_req_if.server             axi,
  input  logic [`BC_ADDR_W-1:0] dbg_addr,
  input  logic [`BC_DATA_W-1:0] dbg_wdata,
  input  logic                  dbg_read_en,
  input  logic                  dbg_write_en,
  output logic [`BC_DATA_W-1:0] dbg_rdata,
  output logic                  dbg_ready,
  mem_req_if.requester          seq
);
  import bram_ctrl_pkg::*;

  owner_e                owner;
  logic                  free;
  logic                  dbg_req_now;
  logic                  grant_axi;
  logic                  grant_dbg_pend;
  logic                  grant_dbg_new;
  logic                  dbg_pend;     // Debug request seen in an earlier cycle
  logic                  dbg_wr_q;
  logic [`BC_ADDR_W-1:0] dbg_addr_q;
  logic [`BC_DATA_W-1:0] dbg_wdata_q;
  logic [`BC_DATA_W-1:0] dbg_rdata_q;
  logic                  seq_valid;
  logic                  seq_write_q;
  logic [`BC_ADDR_W-1:0] seq_addr_q;
  mem_word_u             seq_wdata_q;
  logic [`BC_STRB_W-1:0] seq_wstrb_q;

  // ========================================
  // Priority: latched dbg, AXI, new dbg
  // ========================================
  assign free           = (owner == OWNER_NONE);
  assign dbg_req_now    = dbg_read_en || dbg_write_en;
  assign grant_dbg_pend = free && dbg_pend;
  assign grant_axi      = free && !dbg_pend && axi.valid;
  assign grant_dbg_new  = free && !dbg_pend && !axi.valid && dbg_req_now;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner     <= OWNER_NONE;
      seq_valid <= 1'b0;
      dbg_pend  <= 1'b0;
    end else begin
      if (seq.done) begin
        owner     <= OWNER_NONE;  // Free again next cycle
        seq_valid <= 1'b0;
      end else if (grant_axi) begin
        owner     <= OWNER_AXI;
        seq_valid <= 1'b1;
      end else if (grant_dbg_pend || grant_dbg_new) begin
        owner     <= OWNER_DBG;
        seq_valid <= 1'b1;
      end
      // Debug request lost the race, hold it for later
      if (grant_dbg_pend) dbg_pend <= 1'b0;
      else if (dbg_req_now && owner != OWNER_DBG && !grant_dbg_new) dbg_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dbg_req_now && !dbg_pend) begin
      dbg_wr_q    <= dbg_write_en;
      dbg_addr_q  <= dbg_addr;
      dbg_wdata_q <= dbg_wdata;
    end
    // Request copy for the sequencer, loaded at grant
    if (grant_axi) begin
      seq_write_q <= axi.write;
      seq_addr_q  <= axi.addr;
      seq_wdata_q <= axi.wdata;
      seq_wstrb_q <= axi.wstrb;
    end else if (grant_dbg_pend) begin
      seq_write_q      <= dbg_wr_q;
      seq_addr_q       <= dbg_addr_q;
      seq_wdata_q.word <= dbg_wdata_q;
      seq_wstrb_q      <= {`BC_STRB_W{1'b1}};  // Debug is whole word
    end else if (grant_dbg_new) begin
      seq_write_q      <= dbg_write_en;
      seq_addr_q       <= dbg_addr;
      seq_wdata_q.word <= dbg_wdata;
      seq_wstrb_q      <= {`BC_STRB_W{1'b1}};
    end
    if (dbg_ready) dbg_rdata_q <= seq.rdata.word;
  end

  // ========================================
  // Forward and route completion
  // ========================================
  assign seq.valid = seq_valid;
  assign seq.write = seq_write_q;
  assign seq.addr  = seq_addr_q;
  assign seq.wdata = seq_wdata_q;
  assign seq.wstrb = seq_wstrb_q;

  assign axi.done  = seq.done && (owner == OWNER_AXI);
  assign axi.rdata = seq.rdata;
  assign dbg_ready = seq.done && (owner == OWNER_DBG);
  assign dbg_rdata = dbg_ready ? seq.rdata.word : dbg_rdata_q;  // Held after ready

  // Owner fixed for the whole access
  a_owner_stable: assert property (@(posedge clk) disable iff (!rst_n)
    seq.valid && $past(seq.valid) |-> $stable(owner));
  a_dbg_ready_owner: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_ready |-> owner == OWNER_DBG && $past(seq.valid));

endmodule

// ==== rtl/bram_sequencer.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

module bram_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  mem_req_if.server             req,
  output logic [`BC_ADDR_W-1:0] bram_addr,   // Held until bram_done
  output logic [`BC_DATA_W-1:0] bram_wdata,
  input  logic [`BC_DATA_W-1:0] bram_rdata,
  output logic                  bram_read,   // One cycle pulse
  output logic                  bram_write,  // One cycle pulse
  input  logic                  bram_done
);
  import bram_ctrl_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,   // Waiting for a request
    S_READ,   // Read out, waiting on bram_done
    S_MERGE,  // Strobed bytes over the old word
    S_WRITE   // Write back out, waiting on bram_done
  } state_e;

  state_e    state;
  mem_word_u old_q;   // Word read back for the merge
  mem_word_u merged;

  // ========================================
  // Byte merge
  // ========================================
  always_comb begin
    merged = old_q;
    for (int i = 0; i < `BC_STRB_W; i++) begin
      if (req.wstrb[i]) merged.bytes[i] = req.wdata.bytes[i];  // New lane
    end
  end

  // ========================================
  // BRAM port sequencing
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      bram_read  <= 1'b0;
      bram_write <= 1'b0;
    end else begin
      bram_read  <= 1'b0;  // Pulses by default off
      bram_write <= 1'b0;
      case (state)
        S_IDLE: begin
          if (req.valid) begin
            bram_read <= 1'b1;  // Writes read first too
            state     <= S_READ;
          end
        end
        S_READ: if (bram_done) state <= req.write ? S_MERGE : S_IDLE;
        S_MERGE: begin
          bram_write <= 1'b1;
          state      <= S_WRITE;
        end
        S_WRITE: if (bram_done) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && req.valid) bram_addr <= req.addr;
    if (state == S_READ && bram_done) old_q.word <= bram_rdata;
    if (state == S_MERGE) bram_wdata <= merged.word;
  end

  // Read ends on its own bram_done, write on the second one
  assign req.done = bram_done &&
                    ((state == S_READ && !req.write) || state == S_WRITE);
  assign req.rdata.word = bram_rdata;

  // ========================================
  // Port checks
  // ========================================
  a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
    !(bram_read && bram_write));
  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    (bram_read || bram_write) |=> (!bram_read && !bram_write) until_with bram_done);

endmodule

// ==== rtl/bram_controller.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

module bram_controller (
  input  logic                  clk,
  input  logic                  rst_n,
  // AXI4-Lite slave
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [`BC_ADDR_W-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [`BC_DATA_W-1:0] wdata,
  input  logic [`BC_STRB_W-1:0] wstrb,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [`BC_ADDR_W-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [`BC_DATA_W-1:0] rdata,
  output logic [1:0]            rresp,
  // BRAM port
  output logic [`BC_ADDR_W-1:0] bram_addr,
  output logic [`BC_DATA_W-1:0] bram_wdata,
  input  logic [`BC_DATA_W-1:0] bram_rdata,
  output logic                  bram_read,
  output logic                  bram_write,
  input  logic                  bram_done,
  // Debug port, held until dbg_ready
  input  logic [`BC_ADDR_W-1:0] dbg_addr,
  input  logic [`BC_DATA_W-1:0] dbg_wdata,
  input  logic                  dbg_read_en,
  input  logic                  dbg_write_en,
  output logic [`BC_DATA_W-1:0] dbg_rdata,
  output logic                  dbg_ready
);

  mem_req_if axi_req ();  // Front end to arbiter
  mem_req_if seq_req ();  // Arbiter to sequencer

  axi_lite_front front_i (
    .clk, .rst_n, .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp, .arvalid, .arready, .araddr, .rvalid, .rready,
    .rdata, .rresp, .req(axi_req.requester)
  );

  access_arbiter arbiter_i (
    .clk, .rst_n, .axi(axi_req.server), .dbg_addr, .dbg_wdata, .dbg_read_en,
    .dbg_write_en, .dbg_rdata, .dbg_ready, .seq(seq_req.requester)
  );

  bram_sequencer sequencer_i (
    .clk, .rst_n, .req(seq_req.server), .bram_addr, .bram_wdata, .bram_rdata,
    .bram_read, .bram_write, .bram_done
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== tb/bram_model.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

// Behavioral BRAM, one access at a time, random latency
module bram_model #(
  parameter int SEED    = 1,
  parameter int MIN_LAT = 1,
  parameter int MAX_LAT = 1,
  parameter int WORDS   = 256
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`BC_ADDR_W-1:0] bram_addr,
  input  logic [`BC_DATA_W-1:0] bram_wdata,
  output logic [`BC_DATA_W-1:0] bram_rdata,
  input  logic                  bram_read,
  input  logic                  bram_write,
  output logic                  bram_done
);

  localparam int IDX_W = $clog2(WORDS);

  logic [`BC_DATA_W-1:0] mem [0:WORDS-1];
  int                    seed;
  int                    count;    // Cycles left until bram_done
  logic                  busy;
  logic                  wr_q;
  logic [`BC_ADDR_W-1:0] addr_q;   // Captured at the pulse
  logic [`BC_DATA_W-1:0] wdata_q;

  // Fill from the byte address of each word
  initial begin
    seed = SEED;
    for (int i = 0; i < WORDS; i++) mem[i] = 32'hA5A5_0000 ^ (i * 4);
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      bram_done  <= 1'b0;
      bram_rdata <= '0;
      count      <= 0;
    end else begin
      bram_done <= 1'b0;
      if (bram_read || bram_write) begin
        busy    <= 1'b1;
        wr_q    <= bram_write;
        addr_q  <= bram_addr;
        wdata_q <= bram_wdata;
        count   <= MIN_LAT + $unsigned($random(seed)) % (MAX_LAT - MIN_LAT + 1);
      end else if (busy) begin
        if (count > 1) begin
          count <= count - 1;
        end else begin
          busy       <= 1'b0;
          bram_done  <= 1'b1;                      // One pulse per operation
          bram_rdata <= mem[addr_q[IDX_W+1:2]];
          if (wr_q) mem[addr_q[IDX_W+1:2]] <= wdata_q;
        end
      end
    end
  end

endmodule

// ==== tb/tb_bram_controller.sv ====
`timescale 1ns/1ps
`include "bram_ctrl_consts.svh"

module tb_bram_controller;

  localparam int PERIOD_NS = 100;
  localparam int SEED      = 89697;
  localparam int MIN_LAT   = 1;
  localparam int MAX_LAT   = 4;
  localparam int WORDS     = 32;   // Words touched by the tests
  localparam int N_STRB    = 16;
  localparam int N_SHARE   = 8;
  localparam int N_ACCESS  = 4 * WORDS + 2 * N_STRB + 4 * N_SHARE + 16;
  localparam int WORST_CYC = 2 * MAX_LAT + 12;  // Read-merge-write plus handshakes
  localparam int TIMEOUT_NS = (N_ACCESS * WORST_CYC + 20) * PERIOD_NS;

  logic clk;
  logic rst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [`BC_ADDR_W-1:0] awaddr, araddr, bram_addr, dbg_addr;
  logic [`BC_DATA_W-1:0] wdata, rdata, bram_wdata, bram_rdata, dbg_wdata, dbg_rdata;
  logic [`BC_STRB_W-1:0] wstrb;
  logic [1:0]            bresp, rresp;
  logic bram_read, bram_write, bram_done;
  logic dbg_read_en, dbg_write_en, dbg_ready;

  logic [`BC_DATA_W-1:0] shadow [0:WORDS-1];  // Expected memory contents
  logic [`BC_DATA_W-1:0] exp_rdata;
  logic [`BC_DATA_W-1:0] exp_dbg_rdata;
  logic [`BC_ADDR_W-1:0] exp_first_addr;
  logic [`BC_ADDR_W-1:0] addr;
  logic [`BC_DATA_W-1:0] rnd;
  logic                  first_pending;       // Next bram_read must match
  int seed = SEED;
  int errors = 0;
  int err_start = 0;
  int passed = 0;
  int failed = 0;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) clock_gen_i (.clk, .rst_n);
  bram_controller bram_controller_i (.*);
  bram_model #(.SEED(SEED), .MIN_LAT(MIN_LAT), .MAX_LAT(MAX_LAT)) bram_model_i (.*);

  // ========================================
  // Checks
  // ========================================
  task automatic log_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("ERROR: %s expected %0h actual %0h", sig, exp, act);
  endtask

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rdata == exp_rdata)
    else log_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));
  a_rresp: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rresp == `BC_RESP_OKAY)
    else log_mismatch("rresp", 32'(`BC_RESP_OKAY), 32'($sampled(rresp)));
  a_bresp: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> bresp == `BC_RESP_OKAY)
    else log_mismatch("bresp", 32'(`BC_RESP_OKAY), 32'($sampled(bresp)));
  a_dbg_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_ready && dbg_read_en |-> dbg_rdata == exp_dbg_rdata)
    else log_mismatch("dbg_rdata", $sampled(exp_dbg_rdata), $sampled(dbg_rdata));
  a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
    bram_read && first_pending |-> bram_addr == exp_first_addr)
    else log_mismatch("bram_addr", $sampled(exp_first_addr), $sampled(bram_addr));
  a_bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid) else log_mismatch("bvalid", 32'd1, 32'($sampled(bvalid)));
  a_no_accept: assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> !awready)
    else log_mismatch("awready", 32'd0, 32'($sampled(awready)));
  // W handshake pulses together with AW
  a_w_with_aw: assert property (@(posedge clk) disable iff (!rst_n) wready == awready)
    else log_mismatch("wready", 32'($sampled(awready)), 32'($sampled(wready)));

  // ========================================
  // Bus tasks
  // ========================================
  task automatic shadow_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    shadow[a[6:2]] = (shadow[a[6:2]] & ~mask) | (d & mask);
  endtask

  task automatic axi_write_issue(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = a;
    wvalid  = 1'b1;
    wdata   = d;
    wstrb   = s;
    @(posedge clk);
    while (!awready) @(posedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    shadow_write(a, d, s);
  endtask

  task automatic wait_bresp();
    @(posedge clk);
    while (!(bvalid && bready)) @(posedge clk);
  endtask

  task automatic axi_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
    axi_write_issue(a, d, s);
    wait_bresp();
  endtask

  task automatic axi_read(input logic [31:0] a);
    @(negedge clk);
    exp_rdata = shadow[a[6:2]];
    arvalid   = 1'b1;
    araddr    = a;
    @(posedge clk);
    while (!arready) @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    @(posedge clk);
    while (!rvalid) @(posedge clk);  // rdata checked by a_rdata here
  endtask

  task automatic dbg_access(input logic wr, input logic [31:0] a, input logic [31:0] d);
    @(negedge clk);
    dbg_addr     = a;
    dbg_wdata    = d;
    dbg_write_en = wr;
    dbg_read_en  = !wr;
    if (wr) shadow_write(a, d, 4'hF);  // Debug writes whole words
    else exp_dbg_rdata = shadow[a[6:2]];
    @(posedge clk);
    while (!dbg_ready) @(posedge clk);
    @(negedge clk);
    dbg_write_en = 1'b0;
    dbg_read_en  = 1'b0;
  endtask

  task automatic wait_first_read();
    @(posedge clk);
    while (!bram_read) @(posedge clk);
    @(negedge clk);
    first_pending = 1'b0;
  endtask

  function automatic logic [31:0] rand_addr();
    return ($unsigned($random(seed)) % WORDS) * 4;
  endfunction

  task automatic end_test(input int num, input string name);
    if (errors == err_start) begin
      passed++;
      $display("test %0d %s: passed", num, name);
    end else begin
      failed++;
      $display("test %0d %s: failed, %0d errors", num, name, errors - err_start);
    end
    err_start = errors;
  endtask

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;
    dbg_addr = '0;
    dbg_wdata = '0;
    dbg_read_en = 1'b0;
    dbg_write_en = 1'b0;
    first_pending = 1'b0;
    exp_rdata = '0;
    exp_dbg_rdata = '0;
    exp_first_addr = '0;
    @(posedge rst_n);

    for (int i = 0; i < WORDS; i++) axi_write(i * 4, $random(seed), 4'hF);
    for (int i = 0; i < WORDS; i++) axi_read(i * 4);
    end_test(1, "full word write and read");

    for (int i = 0; i < N_STRB; i++) begin
      addr = rand_addr();
      rnd  = $random(seed);
      axi_write(addr, $random(seed), rnd[3:0]);  // Random byte strobe
      axi_read(addr);
    end
    end_test(2, "partial strobes");

    for (int i = 0; i < N_SHARE; i++) begin
      addr = rand_addr();
      dbg_access(1'b1, addr, $random(seed));
      axi_read(addr);
      addr = rand_addr();
      axi_write(addr, $random(seed), 4'hF);
      dbg_access(1'b0, addr, '0);
    end
    end_test(3, "sharing between masters");

    // Debug a cycle ahead of AXI
    @(negedge clk);
    first_pending  = 1'b1;
    exp_first_addr = 32'h10;
    fork
      dbg_access(1'b0, 32'h10, '0);
      begin
        @(negedge clk);
        axi_write(32'h20, $random(seed), 4'hF);
      end
      wait_first_read();
    join
    axi_read(32'h20);
    // AXI valid reaches the arbiter with the debug request
    @(negedge clk);
    first_pending  = 1'b1;
    exp_first_addr = 32'h30;
    fork
      axi_write(32'h30, $random(seed), 4'h5);
      begin
        @(negedge clk);
        dbg_access(1'b0, 32'h40, '0);
      end
      wait_first_read();
    join
    axi_read(32'h30);
    end_test(4, "priority");

    @(negedge clk);
    bready = 1'b0;
    axi_write_issue(32'h50, $random(seed), 4'hF);
    fork
      axi_write_issue(32'h54, $random(seed), 4'hF);  // Blocked behind the first response
      begin
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        repeat (4) @(negedge clk);
        bready = 1'b1;
      end
    join
    wait_bresp();
    axi_read(32'h54);
    axi_read(32'h50);
    end_test(5, "back-pressure");

    $display("tests passed %0d failed %0d, assertion errors %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: controller stopped responding");
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/bram_ctrl_pkg.sv
common/mem_req_if.sv
rtl/axi_lite_front.sv
rtl/access_arbiter.sv
rtl/bram_sequencer.sv
rtl/bram_controller.sv
tb/tb_clock_gen.sv
tb/bram_model.sv
tb/tb_bram_controller.sv
